/* dv/sysclk_ctrl_props.sv */
`timescale 1ns/1ps

module sysclk_ctrl_props (
	input logic clk_sys_i,
	input logic arst_n_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_i,
	input logic ringosc_en_i
);

	// ack only answers a strobe seen on the previous edge
	ack_after_req: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
		wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
		else $error("ack raised without a preceding cyc and stb");

	// one ack per strobe, never two in a row
	ack_one_cycle: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("ack held for more than one cycle");

	// ring oscillator request off while in reset
	ringosc_off_in_reset: assert property (@(posedge clk_sys_i)
		!arst_n_i |-> !ringosc_en_i)
		else $error("ring oscillator enable high during reset");

endmodule

/* dv/sysclk_ctrl_tb.sv */
`timescale 1ns/1ps
`include "sysclk_ctrl_cfg.svh"

module sysclk_ctrl_tb;
	import sysclk_ctrl_pkg::*;

	localparam int ACK_LIMIT  = 32;
	localparam int POLL_LIMIT = 1000;

	// ring half period in ns
	// the x2 clock runs at half of it
	real ring_half = 3.0;
	// ring cycles per 32k period
	int  n_ref;
	integer seed;
	int errors, checks, test_errs, tests_run, tests_failed;
	string test_name;

	logic clk_sys, arst_n, clk_ring, clk_ring_x2, clk_32k, clk_spi, autodrain;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	wb_addr_t wb_adr;
	wb_data_t wb_wdat, wb_rdat;
	logic ffe_clk, ffe_clk_x2, sm_clk, fifo_rd_clk, clk_32k_out, ringosc_en;

	always #4 clk_sys = ~clk_sys;
	always #(ring_half) clk_ring = ~clk_ring;
	always #(ring_half / 2.0) clk_ring_x2 = ~clk_ring_x2;
	always #5 clk_spi = ~clk_spi;

	// reference edges sit 1 ns off the ring edges, so each period is exactly n_ref ring cycles
	always begin
		#1;
		forever #(ring_half * n_ref) clk_32k = ~clk_32k;
	end

	sysclk_ctrl_top DUT (
		.clk_sys_i        (clk_sys),
		.arst_n_i         (arst_n),
		.clk_ringosc_i    (clk_ring),
		.clk_ringosc_x2_i (clk_ring_x2),
		.clk_32khz_i      (clk_32k),
		.clk_spi_i        (clk_spi),
		.autodrain_busy_i (autodrain),
		.wb_cyc_i         (wb_cyc),
		.wb_stb_i         (wb_stb),
		.wb_we_i          (wb_we),
		.wb_adr_i         (wb_adr),
		.wb_dat_i         (wb_wdat),
		.wb_dat_o         (wb_rdat),
		.wb_ack_o         (wb_ack),
		.ffe_clk_o        (ffe_clk),
		.ffe_clk_x2_o     (ffe_clk_x2),
		.sm_clk_o         (sm_clk),
		.fifo_rd_clk_o    (fifo_rd_clk),
		.clk_32khz_o      (clk_32k_out),
		.ringosc_en_o     (ringosc_en)
	);

	bind sysclk_ctrl_top sysclk_ctrl_props u_props (
		.clk_sys_i    (clk_sys_i),
		.arst_n_i     (arst_n_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_ack_i     (wb_ack_o),
		.ringosc_en_i (ringosc_en_o)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Regression failed");
		$finish;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("Error: %s %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = errors;
	endtask

	task automatic end_test;
		tests_run++;
		if (errors == test_errs) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", test_name, errors - test_errs);
		end
	endtask

	// one classic cycle
	// ack is sampled on the falling edge where it has settled
	task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
		output wb_data_t rdat);
		int waited;
		waited = 0;
		@(posedge clk_sys);
		wb_cyc  <= 1'b1;
		wb_stb  <= 1'b1;
		wb_we   <= we;
		wb_adr  <= adr;
		wb_wdat <= wdat;
		@(negedge clk_sys);
		while (!wb_ack) begin
			if (waited == ACK_LIMIT) begin
				abort_run("Timeout: the Wishbone slave never acknowledged the cycle");
			end
			waited++;
			@(negedge clk_sys);
		end
		rdat = wb_rdat;
		@(posedge clk_sys);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input wb_addr_t adr, input wb_data_t wdat);
		wb_data_t unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	task automatic wb_read(input wb_addr_t adr, output wb_data_t rdat);
		bus_cycle(1'b0, adr, '0, rdat);
	endtask

	// {ffe, ffe x2, sm, fifo rd, 32k, ring enable} from the routing rules
	function automatic logic [5:0] expected_outputs(input clk_ctrl_t c, input logic busy);
		logic [5:0] e;
		e[5] = c[`SYSCLK_BIT_SPI_SEL] ? clk_spi : clk_ring;
		e[4] = c[`SYSCLK_BIT_SPI_SEL] ? clk_spi : clk_ring_x2;
		e[3] = c[`SYSCLK_BIT_SPI_SEL] ? clk_spi : clk_ring;
		e[2] = busy ? clk_ring : clk_spi;
		e[1] = clk_32k & c[`SYSCLK_BIT_32K_EN];
		e[0] = c[`SYSCLK_BIT_SRC_SEL] | c[`SYSCLK_BIT_MAIN_EN];
		return e;
	endfunction

	// stop the unit, set the new period, clear valid, re-enable and poll for the result
	task automatic measure_cal(input int n);
		wb_data_t rd;
		int polls;
		wb_write(wb_addr_t'(`SYSCLK_ADDR_CTRL), '0);
		// any result still crossing lands here
		repeat (16) @(posedge clk_sys);
		n_ref = n;
		wb_read(wb_addr_t'(`SYSCLK_ADDR_CAL), rd);
		wb_write(wb_addr_t'(`SYSCLK_ADDR_CTRL), wb_data_t'(1) << `SYSCLK_BIT_CAL_EN);
		polls = 0;
		wb_read(wb_addr_t'(`SYSCLK_ADDR_CAL), rd);
		while (!rd[`SYSCLK_BIT_CAL_VALID]) begin
			if (polls == POLL_LIMIT) begin
				abort_run("Timeout: calibration result never became valid");
			end
			polls++;
			wb_read(wb_addr_t'(`SYSCLK_ADDR_CAL), rd);
		end
		check_value("count", n, {16'b0, rd[`SYSCLK_CAL_W-1:0]});
		// next result is a whole period away, so the flag must read clear
		wb_read(wb_addr_t'(`SYSCLK_ADDR_CAL), rd);
		check_value("valid after read", 0, {31'b0, rd[`SYSCLK_BIT_CAL_VALID]});
		check_value("count after read", n, {16'b0, rd[`SYSCLK_CAL_W-1:0]});
	endtask

	initial begin
		wb_data_t rd, v;
		clk_ctrl_t c;
		int n1, n2, ofs;
		clk_sys = 1'b0;
		clk_ring = 1'b0;
		clk_ring_x2 = 1'b0;
		clk_spi = 1'b0;
		clk_32k = 1'b0;
		arst_n = 1'b0;
		autodrain = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdat = '0;
		n_ref = 50;
		seed = 27;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;

		begin_test("reset_values");
		// 64 cycles cover more than one 32k period at n_ref 50
		for (int i = 0; i < 64; i++) begin
			@(negedge clk_sys);
			check_value("clk_32khz_o", 0, {31'b0, clk_32k_out});
			check_value("ringosc_en_o", 0, {31'b0, ringosc_en});
			if (i == 15) begin
				@(posedge clk_sys);
				arst_n <= 1'b1;
			end
		end
		check_value("cal state", 32'(CAL_IDLE), 32'(DUT.u_clk_ctrl.u_ring_osc_adjust.state_q));
		wb_read(wb_addr_t'(`SYSCLK_ADDR_CTRL), rd);
		check_value("ctrl", 0, rd);
		wb_read(wb_addr_t'(`SYSCLK_ADDR_CAL), rd);
		check_value("cal", 0, rd);
		end_test();

		begin_test("register_access");
		for (int i = 0; i < 16; i++) begin
			v = $random(seed);
			wb_write(wb_addr_t'(`SYSCLK_ADDR_CTRL), v);
			wb_read(wb_addr_t'(`SYSCLK_ADDR_CTRL), rd);
			check_value("ctrl readback", v & wb_data_t'((1 << `SYSCLK_CTRL_W) - 1), rd);
		end
		for (int i = 0; i < 8; i++) begin
			v = $random(seed);
			wb_write(wb_addr_t'(2 + $unsigned($random(seed)) % 14), v);
			wb_read(wb_addr_t'(2 + $unsigned($random(seed)) % 14), rd);
			check_value("unmapped read", 0, rd);
		end
		end_test();

		begin_test("clock_routing");
		for (int i = 0; i < 12; i++) begin
			c = clk_ctrl_t'($random(seed));
			wb_write(wb_addr_t'(`SYSCLK_ADDR_CTRL), wb_data_t'(c));
			v = $random(seed);
			autodrain <= v[0];
			for (int k = 0; k < 6; k++) begin
				@(posedge clk_sys);
				// quarter ns offset keeps samples clear of every clock edge
				ofs = $unsigned($random(seed)) % 7;
				#(0.25 + ofs);
				check_value("clock outputs", {26'b0, expected_outputs(c, autodrain)},
					{26'b0, ffe_clk, ffe_clk_x2, sm_clk, fifo_rd_clk, clk_32k_out, ringosc_en});
			end
		end
		end_test();

		begin_test("calibration");
		n1 = 20 + $unsigned($random(seed)) % 181;
		measure_cal(n1);
		end_test();

		begin_test("valid_clear_and_recal");
		// a nonzero offset modulo the range always gives a new period
		n2 = 20 + (n1 - 20 + 1 + $unsigned($random(seed)) % 180) % 181;
		measure_cal(n2);
		end_test();

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the sysclk_ctrl testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sysclk_ctrl.f --top-module sysclk_ctrl_tb -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Regression passed" sim.log; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL"
	exit 1
fi

/* sysclk_ctrl.f */
+incdir+verilog
verilog/sysclk_ctrl_pkg.sv
verilog/sysclk_ctrl_regs.sv
verilog/ring_osc_adjust.sv
verilog/sysclk_ctrl.sv
verilog/sysclk_ctrl_top.sv
dv/sysclk_ctrl_props.sv
dv/sysclk_ctrl_tb.sv

/* verilog/ring_osc_adjust.sv */
`timescale 1ns/1ps
`include "sysclk_ctrl_cfg.svh"

module ring_osc_adjust (
	input  logic                      clk_ringosc_i,
	input  logic                      arst_n_i,
	input  logic                      clk_32khz_i,
	input  logic                      enable_i,
	output sysclk_ctrl_pkg::cal_val_t cal_val_o,
	output logic                      cal_toggle_o
);
	import sysclk_ctrl_pkg::*;

	// reference and enable brought into the ring domain
	logic [`SYSCLK_SYNC_STAGES-1:0] ref_sync_q;
	logic [`SYSCLK_SYNC_STAGES-1:0] en_sync_q;
	logic                           ref_prev_q;
	logic                           ref_rise;
	logic                           cal_en;

	// sequencer and counter
	cal_state_t state_q;
	cal_state_t state_d;
	cal_val_t   cnt_q;
	cal_val_t   cnt_inc;

	// published result
	cal_val_t val_q;
	logic     tgl_q;
	logic     publish;

	// both syncs have the same depth so the edge latency is constant
	always_ff @(posedge clk_ringosc_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ref_sync_q <= '0;
			en_sync_q  <= '0;
			ref_prev_q <= 1'b0;
		end else begin
			ref_sync_q <= {ref_sync_q[`SYSCLK_SYNC_STAGES-2:0], clk_32khz_i};
			en_sync_q  <= {en_sync_q[`SYSCLK_SYNC_STAGES-2:0], enable_i};
			ref_prev_q <= ref_sync_q[`SYSCLK_SYNC_STAGES-1];
		end
	end

	// one ring cycle pulse per 32k rising edge
	assign ref_rise = ref_sync_q[`SYSCLK_SYNC_STAGES-1] & ~ref_prev_q;
	assign cal_en   = en_sync_q[`SYSCLK_SYNC_STAGES-1];

	// next state
	// disable wins from any state
	always_comb begin
		state_d = state_q;
		case (state_q)
			CAL_IDLE: begin
				if (cal_en) begin
					state_d = CAL_ARM;
				end
			end
			CAL_ARM: begin
				if (ref_rise) begin
					state_d = CAL_COUNT;
				end
			end
			CAL_COUNT: begin
				state_d = CAL_COUNT;
			end
			default: begin
				state_d = CAL_IDLE;
			end
		endcase
		if (!cal_en) begin
			state_d = CAL_IDLE;
		end
	end

	always_ff @(posedge clk_ringosc_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= CAL_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// saturate at all ones on a very slow reference
	assign cnt_inc = (&cnt_q) ? cnt_q : cnt_q + cal_val_t'(1);

	// counter held at zero until the first reference edge
	// the edge cycle itself is the first cycle of a period, hence the load of one
	always_ff @(posedge clk_ringosc_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else begin
			case (state_q)
				CAL_ARM: begin
					if (ref_rise) begin
						cnt_q <= cal_val_t'(1);
					end else begin
						cnt_q <= '0;
					end
				end
				CAL_COUNT: begin
					if (ref_rise) begin
						cnt_q <= cal_val_t'(1);
					end else begin
						cnt_q <= cnt_inc;
					end
				end
				default: begin
					cnt_q <= '0;
				end
			endcase
		end
	end

	// one result per full period while still enabled
	assign publish = (state_q == CAL_COUNT) & ref_rise & cal_en;

	// value is written together with the toggle flip, then held
	always_ff @(posedge clk_ringosc_i) begin
		if (publish) begin
			val_q <= cnt_q;
		end
	end

	always_ff @(posedge clk_ringosc_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tgl_q <= 1'b0;
		end else if (publish) begin
			tgl_q <= ~tgl_q;
		end
	end

	assign cal_val_o    = val_q;
	assign cal_toggle_o = tgl_q;

endmodule

/* verilog/sysclk_ctrl.sv */
`timescale 1ns/1ps
`include "sysclk_ctrl_cfg.svh"

module sysclk_ctrl (
	input  logic                       clk_ringosc_i,
	input  logic                       clk_ringosc_x2_i,
	input  logic                       clk_32khz_i,
	input  logic                       clk_spi_i,
	input  logic                       arst_n_i,
	input  logic                       autodrain_busy_i,
	input  sysclk_ctrl_pkg::clk_ctrl_t ctrl_i,
	output logic                       ffe_clk_o,
	output logic                       ffe_clk_x2_o,
	output logic                       sm_clk_o,
	output logic                       fifo_rd_clk_o,
	output logic                       clk_32khz_o,
	output logic                       ringosc_en_o,
	output sysclk_ctrl_pkg::cal_val_t  cal_val_o,
	output logic                       cal_toggle_o
);

	// control levels from the register block
	logic spi_clk_sel;
	logic clk32k_en;
	logic main_clk_en;
	logic clk_src_sel;
	logic cal_en;

	assign spi_clk_sel = ctrl_i[`SYSCLK_BIT_SPI_SEL];
	assign clk32k_en   = ctrl_i[`SYSCLK_BIT_32K_EN];
	assign main_clk_en = ctrl_i[`SYSCLK_BIT_MAIN_EN];
	assign clk_src_sel = ctrl_i[`SYSCLK_BIT_SRC_SEL];
	assign cal_en      = ctrl_i[`SYSCLK_BIT_CAL_EN];

	// functional clocks
	// spi clock overrides the ring oscillator for host driven operation
	assign ffe_clk_o    = spi_clk_sel ? clk_spi_i : clk_ringosc_i;
	assign ffe_clk_x2_o = spi_clk_sel ? clk_spi_i : clk_ringosc_x2_i;
	assign sm_clk_o     = spi_clk_sel ? clk_spi_i : clk_ringosc_i;

	// fifo is drained locally on the ring clock,
	// otherwise the host reads it over spi
	assign fifo_rd_clk_o = autodrain_busy_i ? clk_ringosc_i : clk_spi_i;

	// 32k gated off in sleep
	assign clk_32khz_o = clk_32khz_i & clk32k_en;

	// request the ring oscillator when either user needs it
	assign ringosc_en_o = clk_src_sel | main_clk_en;

	// calibration counter in the ring domain
	ring_osc_adjust u_ring_osc_adjust (
		.clk_ringosc_i (clk_ringosc_i),
		.arst_n_i      (arst_n_i),
		.clk_32khz_i   (clk_32khz_i),
		.enable_i      (cal_en),
		.cal_val_o     (cal_val_o),
		.cal_toggle_o  (cal_toggle_o)
	);

endmodule

/* verilog/sysclk_ctrl_cfg.svh */
`ifndef SYSCLK_CTRL_CFG_SVH
`define SYSCLK_CTRL_CFG_SVH

// wishbone word address and data widths
`define SYSCLK_WB_AW 4
`define SYSCLK_WB_DW 32

// ring oscillator cycles per 32 kHz period
`define SYSCLK_CAL_W 16

// flops in each clock domain crossing synchronizer
`define SYSCLK_SYNC_STAGES 2

// register word addresses
`define SYSCLK_ADDR_CTRL 0
`define SYSCLK_ADDR_CAL 1

// control register layout
`define SYSCLK_CTRL_W 5
`define SYSCLK_BIT_SPI_SEL 0
`define SYSCLK_BIT_32K_EN 1
`define SYSCLK_BIT_MAIN_EN 2
`define SYSCLK_BIT_SRC_SEL 3
`define SYSCLK_BIT_CAL_EN 4

// calibration register, valid flag sits above the count
`define SYSCLK_BIT_CAL_VALID 16

`endif

/* verilog/sysclk_ctrl_pkg.sv */
`include "sysclk_ctrl_cfg.svh"

package sysclk_ctrl_pkg;

	// wishbone word address
	typedef logic [`SYSCLK_WB_AW-1:0] wb_addr_t;

	// wishbone data
	typedef logic [`SYSCLK_WB_DW-1:0] wb_data_t;

	// ring oscillator cycles per 32 kHz period
	typedef logic [`SYSCLK_CAL_W-1:0] cal_val_t;

	// spi select, 32k enable, main enable, source select, cal enable
	typedef logic [`SYSCLK_CTRL_W-1:0] clk_ctrl_t;

	// calibration sequencer
	// idle while disabled, arm waits for the first 32k edge,
	// count publishes one result per 32k period
	typedef enum logic [1:0] {
		CAL_IDLE,
		CAL_ARM,
		CAL_COUNT
	} cal_state_t;

endpackage

/* verilog/sysclk_ctrl_regs.sv */
`timescale 1ns/1ps
`include "sysclk_ctrl_cfg.svh"

module sysclk_ctrl_regs (
	input  logic                       clk_sys_i,
	input  logic                       arst_n_i,
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	input  logic                       wb_we_i,
	input  sysclk_ctrl_pkg::wb_addr_t  wb_adr_i,
	input  sysclk_ctrl_pkg::wb_data_t  wb_dat_i,
	input  sysclk_ctrl_pkg::cal_val_t  cal_val_i,
	input  logic                       cal_toggle_i,
	output sysclk_ctrl_pkg::wb_data_t  wb_dat_o,
	output logic                       wb_ack_o,
	output sysclk_ctrl_pkg::clk_ctrl_t ctrl_o
);
	import sysclk_ctrl_pkg::*;

	// bus side
	logic      bus_req;
	logic      wr_ctrl;
	logic      cal_rd;
	logic      ack_q;
	wb_data_t  rd_data;
	wb_data_t  dat_q;
	clk_ctrl_t ctrl_q;

	// calibration result side
	logic [`SYSCLK_SYNC_STAGES-1:0] tgl_sync_q;
	logic                           tgl_seen_q;
	logic                           new_result;
	cal_val_t                       cal_q;
	logic                           cal_valid_q;

	// a strobe counts once, the ack cycle masks it
	assign bus_req = wb_cyc_i & wb_stb_i & ~ack_q;

	// writes land on the same edge that raises ack
	assign wr_ctrl = bus_req & wb_we_i & (wb_adr_i == wb_addr_t'(`SYSCLK_ADDR_CTRL));

	// read of CAL, used to clear the valid flag
	assign cal_rd = bus_req & ~wb_we_i & (wb_adr_i == wb_addr_t'(`SYSCLK_ADDR_CAL));

	// single cycle ack, one cycle after cyc and stb
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= bus_req;
		end
	end

	// control register, only the low bits exist
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ctrl_q <= '0;
		end else if (wr_ctrl) begin
			ctrl_q <= wb_dat_i[`SYSCLK_CTRL_W-1:0];
		end
	end

	// read mux
	// unmapped words return zero
	always_comb begin
		rd_data = '0;
		case (wb_adr_i)
			wb_addr_t'(`SYSCLK_ADDR_CTRL): begin
				rd_data[`SYSCLK_CTRL_W-1:0] = ctrl_q;
			end
			wb_addr_t'(`SYSCLK_ADDR_CAL): begin
				rd_data[`SYSCLK_CAL_W-1:0] = cal_q;
				rd_data[`SYSCLK_BIT_CAL_VALID] = cal_valid_q;
			end
			default: begin
				rd_data = '0;
			end
		endcase
	end

	// read data registered with the ack
	// holds the flag value from before a clear-on-read
	always_ff @(posedge clk_sys_i) begin
		if (bus_req && !wb_we_i) begin
			dat_q <= rd_data;
		end
	end

	// result toggle into the bus domain
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tgl_sync_q <= '0;
			tgl_seen_q <= 1'b0;
		end else begin
			tgl_sync_q <= {tgl_sync_q[`SYSCLK_SYNC_STAGES-2:0], cal_toggle_i};
			tgl_seen_q <= tgl_sync_q[`SYSCLK_SYNC_STAGES-1];
		end
	end

	// any change of the synchronized toggle is one new result
	assign new_result = tgl_sync_q[`SYSCLK_SYNC_STAGES-1] ^ tgl_seen_q;

	// count stays put for a whole 32k period so it is settled here
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cal_q <= '0;
		end else if (new_result) begin
			cal_q <= cal_val_i;
		end
	end

	// valid flag, set beats clear on a shared edge
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cal_valid_q <= 1'b0;
		end else if (new_result) begin
			cal_valid_q <= 1'b1;
		end else if (cal_rd) begin
			cal_valid_q <= 1'b0;
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;
	assign ctrl_o   = ctrl_q;

endmodule

/* verilog/sysclk_ctrl_top.sv */
`timescale 1ns/1ps

module sysclk_ctrl_top (
	input  logic                      clk_sys_i,
	input  logic                      arst_n_i,
	input  logic                      clk_ringosc_i,
	input  logic                      clk_ringosc_x2_i,
	input  logic                      clk_32khz_i,
	input  logic                      clk_spi_i,
	input  logic                      autodrain_busy_i,
	// wishbone slave
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  sysclk_ctrl_pkg::wb_addr_t wb_adr_i,
	input  sysclk_ctrl_pkg::wb_data_t wb_dat_i,
	output sysclk_ctrl_pkg::wb_data_t wb_dat_o,
	output logic                      wb_ack_o,
	// clock outputs
	output logic                      ffe_clk_o,
	output logic                      ffe_clk_x2_o,
	output logic                      sm_clk_o,
	output logic                      fifo_rd_clk_o,
	output logic                      clk_32khz_o,
	output logic                      ringosc_en_o
);
	import sysclk_ctrl_pkg::*;

	// control levels, system domain
	clk_ctrl_t ctrl;

	// calibration handoff, ring domain
	cal_val_t cal_val;
	logic     cal_toggle;

	sysclk_ctrl_regs u_regs (
		.clk_sys_i    (clk_sys_i),
		.arst_n_i     (arst_n_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.cal_val_i    (cal_val),
		.cal_toggle_i (cal_toggle),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.ctrl_o       (ctrl)
	);

	sysclk_ctrl u_clk_ctrl (
		.clk_ringosc_i    (clk_ringosc_i),
		.clk_ringosc_x2_i (clk_ringosc_x2_i),
		.clk_32khz_i      (clk_32khz_i),
		.clk_spi_i        (clk_spi_i),
		.arst_n_i         (arst_n_i),
		.autodrain_busy_i (autodrain_busy_i),
		.ctrl_i           (ctrl),
		.ffe_clk_o        (ffe_clk_o),
		.ffe_clk_x2_o     (ffe_clk_x2_o),
		.sm_clk_o         (sm_clk_o),
		.fifo_rd_clk_o    (fifo_rd_clk_o),
		.clk_32khz_o      (clk_32khz_o),
		.ringosc_en_o     (ringosc_en_o),
		.cal_val_o        (cal_val),
		.cal_toggle_o     (cal_toggle)
	);

endmodule
